// ==== logic/render_cfg.svh ====
// Build-wide drawing parameters.
// RENDER_SCALE multiplies the 160x90 scene by 1, 2, 4 or 8 within 16-bit coordinates.
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// coordinates are signed so that a vertex may sit off screen
`define RENDER_CORDW 16  // bits per coordinate

`define RENDER_CIDXW 2   // 4 colours

// 1 is 160x90, 2 is 320x180, 4 is 640x360, 8 is 1280x720
`define RENDER_SCALE 1

`endif

// ==== logic/gfx_types_pkg.sv ====
// Pixel level types used by every drawing block.
// Widths come from render_cfg.svh.
`include "render_cfg.svh"
`default_nettype none

package gfx_types_pkg;

    // signed screen position, x or y
    typedef logic signed [`RENDER_CORDW-1:0] coord_t;

    // palette index, the palette itself lives downstream
    typedef logic [`RENDER_CIDXW-1:0] cidx_t;

endpackage

`default_nettype wire

// ==== logic/scene_pkg.sv ====
// Fixed cube scene of six triangles in unscaled 160x90 coordinates.
// Colours alternate 1 and 2 so that neighbouring triangles differ.
`default_nettype none

package scene_pkg;
    import gfx_types_pkg::*;

    // one flat-shaded triangle
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        coord_t x2;
        coord_t y2;
        cidx_t  cidx;
    } shape_t;

    localparam int SHAPE_CNT = 6;  // triangles in the scene

    typedef logic [$clog2(SHAPE_CNT)-1:0] shape_id_t;

    // drawn in this order, two triangles per visible face
    localparam shape_t CUBE_SHAPES [SHAPE_CNT] = '{
        '{x0:  65, y0: 30, x1: 115, y1: 30, x2: 115, y2: 80, cidx: 1},  // front, upper
        '{x0:  65, y0: 30, x1: 115, y1: 80, x2:  65, y2: 80, cidx: 2},  // front, lower
        '{x0:  65, y0: 30, x1:  45, y1: 60, x2:  65, y2: 80, cidx: 1},  // side, lower
        '{x0:  45, y0: 10, x1:  65, y1: 30, x2:  45, y2: 60, cidx: 2},  // side, upper
        '{x0:  45, y0: 10, x1:  95, y1: 10, x2:  65, y2: 30, cidx: 1},  // top, left
        '{x0:  95, y0: 10, x1:  65, y1: 30, x2: 115, y2: 30, cidx: 2}   // top, right
    };

endpackage

`default_nettype wire

// ==== logic/draw_line.sv ====
// Bresenham line drawer for any octant, from (x0,y0) to (x1,y1) inclusive.
// Endpoints are sampled on start only. One pixel per cycle with oe high.
`timescale 1ns/100ps
`default_nettype none

module draw_line (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic oe,
    input  wire gfx_types_pkg::coord_t x0,
    input  wire gfx_types_pkg::coord_t y0,
    input  wire gfx_types_pkg::coord_t x1,
    input  wire gfx_types_pkg::coord_t y1,
    output gfx_types_pkg::coord_t x,
    output gfx_types_pkg::coord_t y,
    output logic drawing,
    output logic busy,
    output logic done
);
    import gfx_types_pkg::*;

    localparam int EW = $bits(coord_t) + 2;  // room for 2*err

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_t;
    state_t state;

    coord_t xe, ye;                    // end point
    logic right, down;                 // step directions
    logic signed [EW-1:0] dx, dy;      // dy is kept negative
    logic signed [EW-1:0] err, err2;
    logic signed [EW-1:0] ex, ey;
    logic movx, movy, last;

    always_comb begin
        err2 = err <<< 1;
        movx = (err2 >= dy);
        movy = (err2 <= dx);
        ex   = movx ? dy : '0;
        ey   = movy ? dx : '0;
        last = (x == xe) && (y == ye);
        drawing = (state == DRAW);
        busy    = (state != IDLE);
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;
        case (state)
            INIT: begin
                err   <= dx + dy;  // initial error term
                state <= DRAW;
            end
            DRAW: if (oe) begin
                if (last) begin
                    done  <= 1'b1;
                    state <= IDLE;
                end else begin
                    if (movx) x <= right ? x + coord_t'(1) : x - coord_t'(1);
                    if (movy) y <= down ? y + coord_t'(1) : y - coord_t'(1);
                    err <= err + ex + ey;
                end
            end
            default: if (start) begin
                x     <= x0;
                y     <= y0;
                xe    <= x1;
                ye    <= y1;
                right <= (x1 > x0);
                down  <= (y1 > y0);
                dx    <= (x1 > x0) ? EW'(x1) - EW'(x0) : EW'(x0) - EW'(x1);
                dy    <= (y1 > y0) ? EW'(y0) - EW'(y1) : EW'(y1) - EW'(y0);
                state <= INIT;
            end
        endcase
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end
    end

    // a stalled pixel stays put and stays valid
    assert property (@(posedge clk) disable iff (rst)
        drawing && !oe |=> drawing && $stable(x) && $stable(y));

endmodule

`default_nettype wire

// ==== logic/draw_triangle_fill.sv ====
// Filled triangle by edge walking. Only the span drawer emits pixels.
// Vertices are sampled on start. Every row from the top vertex to the bottom one is drawn.
`timescale 1ns/100ps
`default_nettype none

module draw_triangle_fill (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic oe,
    input  wire gfx_types_pkg::coord_t x0,
    input  wire gfx_types_pkg::coord_t y0,
    input  wire gfx_types_pkg::coord_t x1,
    input  wire gfx_types_pkg::coord_t y1,
    input  wire gfx_types_pkg::coord_t x2,
    input  wire gfx_types_pkg::coord_t y2,
    output gfx_types_pkg::coord_t x,
    output gfx_types_pkg::coord_t y,
    output logic drawing,
    output logic busy,
    output logic done
);
    import gfx_types_pkg::*;

    typedef enum logic [3:0] {
        IDLE, SORT_0, SORT_1, SORT_2, EDGE_START, EDGE_WAIT, ROW_INIT,
        WALK_A, WALK_B, B_NEXT, B_WAIT, SPAN_START, SPAN_DRAW
    } state_t;
    state_t state;

    coord_t vx [3];          // sorted top to bottom after SORT_2
    coord_t vy [3];
    coord_t row, xmin, xmax;
    coord_t a_x, a_y, b_x, b_y;
    coord_t bx0, by0, bx1, by1;
    logic b_second;          // short edge is on its lower half
    logic a_fin;             // long edge has reached the bottom
    logic a_start, a_step, a_oe, a_drawing, a_busy, a_done;
    logic b_start, b_step, b_oe, b_drawing, b_busy, b_done;
    logic span_start, span_busy, span_done;

    always_comb begin
        a_step = (state == WALK_A) && a_drawing && (a_y == row);
        b_step = (state == WALK_B) && b_drawing && (b_y == row);
        a_oe   = a_step && oe;
        b_oe   = b_step && oe;
        a_start    = (state == EDGE_START) && !a_busy && !b_busy;
        b_start    = a_start || (state == B_NEXT);
        span_start = (state == SPAN_START) && !span_busy;
        bx0 = b_second ? vx[1] : vx[0];
        by0 = b_second ? vy[1] : vy[0];
        bx1 = b_second ? vx[2] : vx[1];
        by1 = b_second ? vy[2] : vy[1];
        busy = (state != IDLE);
    end

    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (a_done) a_fin <= 1'b1;
        case (state)
            IDLE: if (start) begin
                vx[0]    <= x0;
                vy[0]    <= y0;
                vx[1]    <= x1;
                vy[1]    <= y1;
                vx[2]    <= x2;
                vy[2]    <= y2;
                b_second <= 1'b0;
                a_fin    <= 1'b0;
                state    <= SORT_0;
            end
            SORT_0, SORT_2: begin  // order the top pair
                if (vy[0] > vy[1]) begin
                    vx[0] <= vx[1];
                    vy[0] <= vy[1];
                    vx[1] <= vx[0];
                    vy[1] <= vy[0];
                end
                state <= (state == SORT_0) ? SORT_1 : EDGE_START;
            end
            SORT_1: begin  // order the bottom pair
                if (vy[1] > vy[2]) begin
                    vx[1] <= vx[2];
                    vy[1] <= vy[2];
                    vx[2] <= vx[1];
                    vy[2] <= vy[1];
                end
                state <= SORT_2;
            end
            EDGE_START: if (a_start) begin
                row   <= vy[0];
                state <= EDGE_WAIT;
            end
            EDGE_WAIT: if (a_drawing && b_drawing) state <= ROW_INIT;
            ROW_INIT: begin  // long edge always has a pixel on this row
                xmin  <= a_x;
                xmax  <= a_x;
                state <= WALK_A;
            end
            WALK_A: begin
                if (a_oe) begin
                    if (a_x < xmin) xmin <= a_x;
                    if (a_x > xmax) xmax <= a_x;
                end else if (!a_step) begin
                    state <= WALK_B;
                end
            end
            WALK_B: begin
                if (b_oe) begin
                    if (b_x < xmin) xmin <= b_x;
                    if (b_x > xmax) xmax <= b_x;
                end else if (!b_step) begin
                    if (b_done && !b_second) begin  // turn at the middle vertex
                        b_second <= 1'b1;
                        state    <= B_NEXT;
                    end else begin
                        state <= SPAN_START;
                    end
                end
            end
            B_NEXT: state <= B_WAIT;
            B_WAIT: if (b_drawing) state <= WALK_B;
            SPAN_START: if (span_start) state <= SPAN_DRAW;
            SPAN_DRAW: if (span_done) begin
                if (a_fin) begin  // bottom row finished
                    done  <= 1'b1;
                    state <= IDLE;
                end else begin
                    row   <= row + coord_t'(1);
                    state <= ROW_INIT;
                end
            end
            default: state <= IDLE;
        endcase
        if (rst) begin
            state    <= IDLE;
            done     <= 1'b0;
            b_second <= 1'b0;
            a_fin    <= 1'b0;
        end
    end

    draw_line edge_a_inst (  // long edge, top to bottom
        .clk, .rst, .start(a_start), .oe(a_oe),
        .x0(vx[0]), .y0(vy[0]), .x1(vx[2]), .y1(vy[2]),
        .x(a_x), .y(a_y), .drawing(a_drawing), .busy(a_busy), .done(a_done)
    );

    draw_line edge_b_inst (  // short edges via the middle vertex
        .clk, .rst, .start(b_start), .oe(b_oe),
        .x0(bx0), .y0(by0), .x1(bx1), .y1(by1),
        .x(b_x), .y(b_y), .drawing(b_drawing), .busy(b_busy), .done(b_done)
    );

    draw_line span_inst (
        .clk, .rst, .start(span_start), .oe,
        .x0(xmin), .y0(row), .x1(xmax), .y1(row),
        .x, .y, .drawing, .busy(span_busy), .done(span_done)
    );

    // the sequencer waits for completion before the next triangle
    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// ==== logic/render_cube_fill.sv ====
// Scene sequencer. Draws CUBE_SHAPES in table order, scaled by RENDER_SCALE.
// done holds until reset, so a later start has no effect.
`timescale 1ns/100ps
`default_nettype none
`include "render_cfg.svh"

module render_cube_fill (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic oe,
    output gfx_types_pkg::coord_t x,
    output gfx_types_pkg::coord_t y,
    output gfx_types_pkg::cidx_t cidx,
    output logic drawing,
    output logic done
);
    import gfx_types_pkg::*;
    import scene_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW, DONE} state_t;
    state_t state;

    shape_id_t shape_id;
    shape_t shape;
    coord_t vx0, vy0, vx1, vy1, vx2, vy2;  // scaled vertices
    logic tri_start, tri_busy, tri_done;

    function automatic coord_t scale(input coord_t v);
        return coord_t'(v * `RENDER_SCALE);
    endfunction

    always_comb begin
        shape = CUBE_SHAPES[shape_id];
        done  = (state == DONE);
    end

    always_ff @(posedge clk) begin
        case (state)
            INIT: if (!tri_busy) begin
                vx0       <= scale(shape.x0);
                vy0       <= scale(shape.y0);
                vx1       <= scale(shape.x1);
                vy1       <= scale(shape.y1);
                vx2       <= scale(shape.x2);
                vy2       <= scale(shape.y2);
                cidx      <= shape.cidx;
                tri_start <= 1'b1;  // vertices are valid from the next cycle
                state     <= DRAW;
            end
            DRAW: begin
                tri_start <= 1'b0;
                if (tri_done) begin
                    if (int'(shape_id) == SHAPE_CNT - 1) begin
                        state <= DONE;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= INIT;
                    end
                end
            end
            DONE: state <= DONE;
            default: if (start) begin
                shape_id <= '0;
                state    <= INIT;
            end
        endcase
        if (rst) begin
            state     <= IDLE;
            shape_id  <= '0;
            tri_start <= 1'b0;
        end
    end

    draw_triangle_fill tri_fill_inst (
        .clk, .rst, .start(tri_start), .oe,
        .x0(vx0), .y0(vy0), .x1(vx1), .y1(vy1), .x2(vx2), .y2(vy2),
        .x, .y, .drawing, .busy(tri_busy), .done(tri_done)
    );

    // the table index never runs past the last shape
    assert property (@(posedge clk) disable iff (rst) int'(shape_id) < SHAPE_CNT);

endmodule

`default_nettype wire

// ==== logic/cube_render_top.sv ====
// Cube renderer top level. Pixels leave under a valid/ready handshake.
// pix_ready is the drawers' output enable, so back-pressure stalls the drawing itself.
`timescale 1ns/100ps
`default_nettype none

module cube_render_top (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,     // begins the drawing
    input  wire logic pix_ready,
    output logic pix_valid,
    output gfx_types_pkg::coord_t pix_x,
    output gfx_types_pkg::coord_t pix_y,
    output gfx_types_pkg::cidx_t pix_cidx,
    output logic done            // high until reset
);

    render_cube_fill render_inst (
        .clk,
        .rst,
        .start,
        .oe(pix_ready),
        .x(pix_x),
        .y(pix_y),
        .cidx(pix_cidx),
        .drawing(pix_valid),  // the registered pixel is valid
        .done
    );

endmodule

`default_nettype wire

// ==== testbench/tb_cube_render.sv ====
// Directed tests for the cube renderer at the scale set in render_cfg.svh.
// Shapes are told apart by colour changes, which relies on alternating colours.
`timescale 1ns/100ps
`default_nettype none
`include "render_cfg.svh"

module tb_cube_render;
    import gfx_types_pkg::*;

    localparam int S = `RENDER_SCALE;
    // x0, y0, x1, y1, x2, y2, colour of each triangle, unscaled
    localparam int SHAPE_TAB [6][7] = '{
        '{65, 30, 115, 30, 115, 80, 1},
        '{65, 30, 115, 80, 65, 80, 2},
        '{65, 30, 45, 60, 65, 80, 1},
        '{45, 10, 65, 30, 45, 60, 2},
        '{45, 10, 95, 10, 65, 30, 1},
        '{95, 10, 65, 30, 115, 30, 2}
    };

    logic clk = 1'b0;
    logic rst;
    logic start;
    logic pix_ready = 1'b0;
    logic pix_valid;
    coord_t pix_x;
    coord_t pix_y;
    cidx_t pix_cidx;
    logic done;

    int seed;
    int rnd;
    logic random_ready = 1'b0;
    logic capture = 1'b0;
    int cap_x [$];
    int cap_y [$];
    int cap_c [$];
    int cap_run [$];
    int run_colour [$];
    int ref_count;
    logic [31:0] ref_sum;
    logic stalled = 1'b0;
    int held_x, held_y, held_c;

    cube_render_top cube_render_top_inst (
        .clk, .rst, .start, .pix_ready,
        .pix_valid, .pix_x, .pix_y, .pix_cidx, .done
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        rnd = $random(seed);
        pix_ready <= random_ready ? rnd[0] : 1'b1;
    end

    task automatic end_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_eq(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    // transfers and the hold rule, sampled midway through the cycle
    always @(negedge clk) begin
        if (!rst && stalled) begin
            check_eq(pix_valid, 1, "pix_valid dropped without a transfer");
            check_eq(int'(pix_x), held_x, "pix_x changed while stalled");
            check_eq(int'(pix_y), held_y, "pix_y changed while stalled");
            check_eq(int'(pix_cidx), held_c, "pix_cidx changed while stalled");
        end
        if (capture && pix_valid && pix_ready) begin
            cap_x.push_back(int'(pix_x));
            cap_y.push_back(int'(pix_y));
            cap_c.push_back(int'(pix_cidx));
        end
        stalled = !rst && pix_valid && !pix_ready;
        held_x = int'(pix_x);
        held_y = int'(pix_y);
        held_c = int'(pix_cidx);
    end

    function automatic int scene_area();
        int sum;
        int det;
        sum = 0;
        for (int k = 0; k < 6; k++) begin
            det = (SHAPE_TAB[k][2] - SHAPE_TAB[k][0]) * (SHAPE_TAB[k][5] - SHAPE_TAB[k][1])
                - (SHAPE_TAB[k][4] - SHAPE_TAB[k][0]) * (SHAPE_TAB[k][3] - SHAPE_TAB[k][1]);
            sum += (det < 0 ? -det : det) / 2;
        end
        return sum * S * S;
    endfunction

    // worst case for one drawing, about four cycles per pixel
    function automatic int drawing_cycles();
        return scene_area() * 4 + 2000;
    endfunction

    function automatic int min3(input int a, input int b, input int c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic logic [31:0] checksum();
        logic [31:0] s;
        s = 32'h1;
        foreach (cap_x[i])
            s = {s[26:0], s[31:27]} ^ (32'(cap_x[i]) * 32'd4099 + 32'(cap_y[i]) * 32'd17
                + 32'(cap_c[i]));  // rotation makes it order sensitive
        return s;
    endfunction

    task automatic clear_capture();
        cap_x.delete();
        cap_y.delete();
        cap_c.delete();
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (!done && n < drawing_cycles()) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("done did not rise within %0d cycles of start", drawing_cycles());
            end_with_failure();
        end
    endtask

    task automatic draw_scene();
        clear_capture();
        capture = 1'b1;
        pulse_start();
        wait_for_done();
        capture = 1'b0;
    endtask

    task automatic split_runs();
        int k;
        cap_run.delete();
        run_colour.delete();
        k = -1;
        foreach (cap_c[i]) begin
            if (i == 0 || cap_c[i] != cap_c[i-1]) begin  // new shape starts
                k++;
                run_colour.push_back(cap_c[i]);
            end
            cap_run.push_back(k);
        end
    endtask

    // rst is already high from time zero, so it is seen on two rising edges
    task automatic test_reset_state();
        @(negedge clk);
        check_eq(pix_valid, 0, "pix_valid during reset");
        check_eq(done, 0, "done during reset");
        @(posedge clk);
        rst <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_eq(pix_valid, 0, "pix_valid without start");
            check_eq(done, 0, "done without start");
        end
    endtask

    task automatic test_colour_order();
        random_ready = 1'b0;
        draw_scene();
        split_runs();
        check_eq(run_colour.size(), 6, "number of colour runs");
        for (int k = 0; k < 6; k++)
            check_eq(run_colour[k], SHAPE_TAB[k][6], $sformatf("colour of run %0d", k));
        repeat (10) begin
            @(negedge clk);
            check_eq(done, 1, "done held after the drawing");
        end
        ref_count = cap_x.size();
        ref_sum = checksum();
    endtask

    task automatic test_geometry();
        int xlo, xhi, ylo, yhi;
        logic [2:0] found;
        logic in_box;
        for (int k = 0; k < 6; k++) begin
            xlo = S * min3(SHAPE_TAB[k][0], SHAPE_TAB[k][2], SHAPE_TAB[k][4]);
            xhi = S * max3(SHAPE_TAB[k][0], SHAPE_TAB[k][2], SHAPE_TAB[k][4]);
            ylo = S * min3(SHAPE_TAB[k][1], SHAPE_TAB[k][3], SHAPE_TAB[k][5]);
            yhi = S * max3(SHAPE_TAB[k][1], SHAPE_TAB[k][3], SHAPE_TAB[k][5]);
            found = '0;
            foreach (cap_x[i]) begin
                if (cap_run[i] == k) begin
                    in_box = cap_x[i] >= xlo && cap_x[i] <= xhi
                          && cap_y[i] >= ylo && cap_y[i] <= yhi;
                    if (!in_box)
                        check_eq(0, 1, $sformatf("pixel (%0d,%0d) inside box of shape %0d",
                            cap_x[i], cap_y[i], k));
                    for (int v = 0; v < 3; v++)
                        if (cap_x[i] == S * SHAPE_TAB[k][2*v]
                                && cap_y[i] == S * SHAPE_TAB[k][2*v+1])
                            found[v] = 1'b1;
                end
            end
            for (int v = 0; v < 3; v++)
                check_eq(found[v], 1, $sformatf("vertex %0d of shape %0d drawn", v, k));
        end
    endtask

    task automatic test_back_pressure();
        apply_reset();
        random_ready = 1'b1;
        draw_scene();
        random_ready = 1'b0;
        check_eq(cap_x.size(), ref_count, "pixel count under back-pressure");
        check_eq(int'(checksum()), int'(ref_sum), "pixel checksum under back-pressure");
    endtask

    task automatic test_restart();
        check_eq(done, 1, "done before a second start");
        clear_capture();
        capture = 1'b1;
        pulse_start();
        repeat (20) @(negedge clk);
        capture = 1'b0;
        check_eq(cap_x.size(), 0, "pixels after a start while done");
        check_eq(done, 1, "done after a start while done");
        apply_reset();
        draw_scene();
        check_eq(cap_x.size(), ref_count, "pixel count after reset");
        check_eq(int'(checksum()), int'(ref_sum), "pixel checksum after reset");
    endtask

    // room for four slow drawings plus slack
    initial begin
        int limit;
        limit = 4 * drawing_cycles() + 10000;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", limit);
        end_with_failure();
    end

    initial begin
        seed = 32'ha894;
        rst = 1'b1;
        start = 1'b0;
        test_reset_state();
        test_colour_order();
        test_geometry();
        test_back_pressure();
        test_restart();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/gfx_types_pkg.sv
logic/scene_pkg.sv
logic/draw_line.sv
logic/draw_triangle_fill.sv
logic/render_cube_fill.sv
logic/cube_render_top.sv
testbench/tb_cube_render.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cube renderer testbench with Verilator and runs it.
# The exit status is the simulator's own.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_cube_render -f project.f -o sim_cube_render; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cube_render
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
else
    echo "simulation ended normally"
fi
exit "$status"
